//--- all.f
design/isa_pkg.sv
design/fetch_pkg.sv
design/icache_array.sv
design/icache_refill.sv
design/icache.sv
design/ifu.sv
design/fetch_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Makefile
# verilator build and run, override any variable on the command line
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
TIMESCALE  ?= 1ns/10ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)
PASS_TEXT  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_top.sv
`timescale 1ns/10ps

module tb_top import fetch_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int MAX_GAP      = 2;
	localparam int MAX_STALL    = 3;
	localparam int NAME_CHARS   = 12;
	localparam int ROW_COUNT    = 15;
	// worst case per row is a full burst with gaps plus a stall, doubled for margin
	localparam int CYCLE_LIMIT  = RESET_CYCLES
		+ ROW_COUNT * (LINE_WORDS + MAX_GAP + MAX_STALL) * 2;

	// last word of the second line holds a fence.i
	localparam logic [ADDR_WIDTH-1:0] FENCE_PC = 32'h3000_001C;

	// one delivery per row, then the action that launches the next fetch
	typedef struct packed {
		logic [8*NAME_CHARS-1:0] name;
		logic                    jump;
		logic [ADDR_WIDTH-1:0]   target;
		logic [3:0]              stall;
		logic                    refill;
	} row_t;

	// name, jump after delivery, jump target, decode stall, burst expected
	localparam row_t ROWS [ROW_COUNT] = '{
		'{"reset_fetch", 1'b0, 32'h0000_0000, 4'd0, 1'b1},
		'{"step_w1",     1'b0, 32'h0000_0000, 4'd0, 1'b0},
		'{"stall_w2",    1'b0, 32'h0000_0000, 4'd2, 1'b0},
		'{"step_w3",     1'b0, 32'h0000_0000, 4'd0, 1'b0},
		'{"next_line",   1'b0, 32'h0000_0000, 4'd0, 1'b1},
		'{"stall_l1w1",  1'b1, 32'h3000_0008, 4'd3, 1'b0},
		'{"jump_back",   1'b0, 32'h0000_0000, 4'd0, 1'b0},
		'{"step_back",   1'b1, 32'h3000_0018, 4'd0, 1'b0},
		'{"jump_fwd",    1'b0, 32'h0000_0000, 4'd0, 1'b0},
		'{"fence_word",  1'b1, 32'h3000_0004, 4'd1, 1'b0},
		'{"after_fence", 1'b0, 32'h0000_0000, 4'd0, 1'b1},
		'{"refetch_w2",  1'b1, 32'h3000_0400, 4'd0, 1'b0},
		'{"far_line",    1'b1, 32'h3000_0000, 4'd2, 1'b1},
		'{"evicted",     1'b0, 32'h0000_0000, 4'd0, 1'b1},
		'{"final_step",  1'b0, 32'h0000_0000, 4'd0, 1'b0}
	};

	logic                    clock = 1'b0;
	logic                    reset;
	logic                    jump_valid;
	logic [ADDR_WIDTH-1:0]   jump_pc;
	logic                    retire;
	logic                    dec_ready;
	logic                    dec_valid;
	fetch_out_t              dec_out;
	mem_req_t                mem_req;
	mem_resp_t               mem_resp;
	logic [8*NAME_CHARS-1:0] row_name;
	logic                    row_refill;
	int                      check_count;
	int                      error_count;
	int                      cycle_count;
	integer                  seed;

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// memory contents by rule, fence.i is misc-mem with funct3 001 and zero fields
	function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
		if (addr == FENCE_PC) begin
			return 32'h0000_100F;
		end else begin
			return addr ^ 32'h0013_0000;
		end
	endfunction

	// beats in address order, random idle cycles before each one
	task automatic serve_burst(input logic [ADDR_WIDTH-1:0] base, input int beats);
		int gap;
		for (int b = 0; b < beats; b++) begin
			gap = int'($unsigned($random(seed)) % (MAX_GAP + 1));
			if (gap > 0) begin
				mem_resp <= '0;
				repeat (gap) @(posedge clock);
			end
			mem_resp <= '{beat: 1'b1, data: mem_word(base + ADDR_WIDTH'(4 * b)),
				last: (b == beats - 1)};
			@(posedge clock);
		end
		mem_resp <= '0;
	endtask

	// burst memory, answers each rising request
	initial begin
		mem_resp <= '0;
		forever begin
			@(posedge clock);
			if (!reset && mem_req.valid) begin
				serve_burst(mem_req.addr, int'(mem_req.len) + 1);
			end
		end
	end

	// decode stand-in, holds ready low for the stall count once valid shows
	task automatic deliver(input int stall);
		dec_ready <= (stall == 0);
		do begin
			@(posedge clock);
		end while (!dec_valid);
		if (stall > 0) begin
			repeat (stall - 1) @(posedge clock);
			dec_ready <= 1'b1;
			@(posedge clock);
		end
	endtask

	task automatic jump_to(input logic [ADDR_WIDTH-1:0] target);
		jump_valid <= 1'b1;
		jump_pc    <= target;
		@(posedge clock);
		jump_valid <= 1'b0;
	endtask

	// also restarts the fetch, after a jump this fetches the target itself
	task automatic retire_once();
		retire <= 1'b1;
		@(posedge clock);
		retire <= 1'b0;
	endtask

	task automatic finish_run(input logic timed_out);
		$display("checks: %0d  errors: %0d  timeout: %0d", check_count, error_count, timed_out);
		if (error_count == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	initial begin
		seed       = 32'h541f7751;
		reset      <= 1'b1;
		jump_valid <= 1'b0;
		jump_pc    <= '0;
		retire     <= 1'b0;
		dec_ready  <= 1'b0;
		row_name   <= '0;
		row_refill <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < ROW_COUNT; i++) begin
			row_name   <= ROWS[i].name;
			row_refill <= ROWS[i].refill;
			deliver(int'(ROWS[i].stall));
			// no fetch after the final row
			if (i < ROW_COUNT - 1) begin
				if (ROWS[i].jump) begin
					jump_to(ROWS[i].target);
				end
				retire_once();
			end
		end
		repeat (2) @(posedge clock);
		finish_run(1'b0);
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: the run was still going after %0d cycles", CYCLE_LIMIT);
		finish_run(1'b1);
	end

	fetch_top fetch_top_inst (
		.clock        (clock),
		.reset        (reset),
		.jump_valid_i (jump_valid),
		.jump_pc_i    (jump_pc),
		.retire_i     (retire),
		.dec_ready_i  (dec_ready),
		.dec_valid_o  (dec_valid),
		.dec_out_o    (dec_out),
		.mem_resp_i   (mem_resp),
		.mem_req_o    (mem_req)
	);

	tb_checker #(
		.FENCE_PC   (FENCE_PC),
		.NAME_CHARS (NAME_CHARS)
	) checker_inst (
		.clock         (clock),
		.reset         (reset),
		.jump_valid_i  (jump_valid),
		.jump_pc_i     (jump_pc),
		.retire_i      (retire),
		.dec_ready_i   (dec_ready),
		.dec_valid_i   (dec_valid),
		.dec_out_i     (dec_out),
		.mem_req_i     (mem_req),
		.row_name_i    (row_name),
		.row_refill_i  (row_refill),
		.check_count_o (check_count),
		.error_count_o (error_count)
	);

endmodule

//--- dv/tb_checker.sv
`timescale 1ns/10ps

module tb_checker import fetch_pkg::*, isa_pkg::*; #(
	parameter logic [ADDR_WIDTH-1:0] FENCE_PC   = '0,
	parameter int                    NAME_CHARS = 12
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    jump_valid_i,
	input  logic [ADDR_WIDTH-1:0]   jump_pc_i,
	input  logic                    retire_i,
	input  logic                    dec_ready_i,
	input  logic                    dec_valid_i,
	input  fetch_out_t              dec_out_i,
	input  mem_req_t                mem_req_i,
	// current stimulus row
	input  logic [8*NAME_CHARS-1:0] row_name_i,
	input  logic                    row_refill_i,
	output int                      check_count_o,
	output int                      error_count_o
);

	localparam int LINE_BYTES = LINE_WORDS * 4;

	// counter model
	logic [ADDR_WIDTH-1:0] pc_model;
	logic                  jump_pend;
	// line model with the base address per index
	logic [LINE_COUNT-1:0] line_valid;
	logic [ADDR_WIDTH-1:0] line_base [LINE_COUNT];
	logic                  req_prev;
	logic                  burst_seen;
	logic                  stalled;
	logic                  fetch_owed;
	fetch_out_t            held;

	// address xor pattern and a fence.i built from its fields
	function automatic logic [WORD_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
		if (addr == FENCE_PC) begin
			return {17'd0, FUNCT3_FENCE_I, 5'd0, OPCODE_MISC_MEM};
		end else begin
			return addr ^ 32'h0013_0000;
		end
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] base_of(input logic [ADDR_WIDTH-1:0] addr);
		return addr & ~ADDR_WIDTH'(LINE_BYTES - 1);
	endfunction

	function automatic int index_of(input logic [ADDR_WIDTH-1:0] addr);
		return int'((addr / ADDR_WIDTH'(LINE_BYTES)) % ADDR_WIDTH'(LINE_COUNT));
	endfunction

	task automatic compare(input string what, input logic [ADDR_WIDTH-1:0] expected,
		input logic [ADDR_WIDTH-1:0] actual);
		check_count_o++;
		if (expected !== actual) begin
			error_count_o++;
			$display("FAILED %s %s: expected %h actual %h", row_name_i, what, expected, actual);
		end
	endtask

	// sampled at the edge so values belong to the cycle just ended
	always @(posedge clock) begin
		int   idx;
		logic hit;
		if (reset) begin
			pc_model   = RESET_PC;
			jump_pend  = 1'b0;
			line_valid = '0;
			req_prev   = 1'b0;
			burst_seen = 1'b0;
			stalled    = 1'b0;
			fetch_owed = 1'b1;
		end else begin
			// stalled pair must stay on the port
			if (stalled) begin
				compare("held valid", 1, dec_valid_i);
				compare("held pc", held.pc, dec_out_i.pc);
				compare("held inst", held.inst, dec_out_i.inst);
			end
			stalled = dec_valid_i && !dec_ready_i;
			held    = dec_out_i;

			// at most one burst start per delivery
			if (mem_req_i.valid && !req_prev) begin
				if (burst_seen) begin
					error_count_o++;
					$display("%s: a second burst started before the delivery", row_name_i);
				end
				burst_seen = 1'b1;
				compare("burst addr", base_of(pc_model), mem_req_i.addr);
				compare("burst len", LINE_WORDS - 1, mem_req_i.len);
			end
			req_prev = mem_req_i.valid;

			// transfer to decode
			if (dec_valid_i && dec_ready_i) begin
				// each fetch is handed over once
				if (!fetch_owed) begin
					error_count_o++;
					$display("%s: a delivery came with no fetch outstanding", row_name_i);
				end
				fetch_owed = 1'b0;
				idx = index_of(pc_model);
				hit = line_valid[idx] && (line_base[idx] == base_of(pc_model));
				compare("pc", pc_model, dec_out_i.pc);
				compare("inst", expected_word(pc_model), dec_out_i.inst);
				compare("refill", row_refill_i, burst_seen);
				compare("line model", !hit, burst_seen);
				if (!hit) begin
					line_valid[idx] = 1'b1;
					line_base[idx]  = base_of(pc_model);
				end
				// fence.i drops every line
				if (pc_model == FENCE_PC) begin
					line_valid = '0;
				end
				burst_seen = 1'b0;
				jump_pend  = 1'b0;
			end

			// back end inputs move the counter
			if (jump_valid_i) begin
				pc_model  = jump_pc_i;
				jump_pend = 1'b1;
			end else if (retire_i && !jump_pend) begin
				pc_model = pc_model + 4;
			end
			// retire starts the next fetch
			if (retire_i) begin
				fetch_owed = 1'b1;
			end
		end
	end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// back end stand-in
	input  logic                  jump_valid_i,
	input  logic [ADDR_WIDTH-1:0] jump_pc_i,
	input  logic                  retire_i,

	// decode port
	input  logic                  dec_ready_i,
	output logic                  dec_valid_o,
	output fetch_out_t            dec_out_o,

	// burst read memory port
	input  mem_resp_t             mem_resp_i,
	output mem_req_t              mem_req_o
);

	// front end, cache lives inside
	ifu ifu_inst (
		.clock        (clock),
		.reset        (reset),
		.jump_valid_i (jump_valid_i),
		.jump_pc_i    (jump_pc_i),
		.retire_i     (retire_i),
		.dec_ready_i  (dec_ready_i),
		.dec_valid_o  (dec_valid_o),
		.dec_out_o    (dec_out_o),
		.mem_resp_i   (mem_resp_i),
		.mem_req_o    (mem_req_o)
	);

endmodule

//--- design/ifu.sv
`timescale 1ns/10ps

module ifu import fetch_pkg::*, isa_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// back end stand-in
	input  logic                  jump_valid_i,
	input  logic [ADDR_WIDTH-1:0] jump_pc_i,
	input  logic                  retire_i,

	// decode side
	input  logic                  dec_ready_i,
	output logic                  dec_valid_o,
	output fetch_out_t            dec_out_o,

	// memory port, passed through the cache
	input  mem_resp_t             mem_resp_i,
	output mem_req_t              mem_req_o
);

	logic [ADDR_WIDTH-1:0] pc_q;
	logic                  jump_pend_q;
	logic                  fetch_valid_q;

	logic                  cache_ready;
	logic [WORD_WIDTH-1:0] cache_data;

	fetch_out_t            fresh;
	fetch_out_t            hold_q;
	logic                  hold_valid_q;

	logic [INST_WIDTH-1:0] dec_inst;
	logic                  flush;

	// program counter
	// jump loads the target, retire steps unless a jump is pending
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else if (jump_valid_i) begin
			pc_q <= jump_pc_i;
		end else if (retire_i && !jump_pend_q) begin
			pc_q <= pc_q + ADDR_WIDTH'(4);
		end
	end

	// pending jump, cleared by the next cache answer
	always_ff @(posedge clock) begin
		if (reset) begin
			jump_pend_q <= 1'b0;
		end else if (jump_valid_i) begin
			jump_pend_q <= 1'b1;
		end else if (cache_ready) begin
			jump_pend_q <= 1'b0;
		end
	end

	// request level, up once out of reset and again on each retire
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid_q <= 1'b1;
		end else if (cache_ready) begin
			fetch_valid_q <= 1'b0;
		end else if (retire_i) begin
			fetch_valid_q <= 1'b1;
		end
	end

	// live counter with the word just returned
	assign fresh.pc   = pc_q;
	assign fresh.inst = cache_data;

	// hold flag, set when decode misses the fresh result
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid_q <= 1'b0;
		end else if (cache_ready) begin
			hold_valid_q <= !dec_ready_i;
		end else if (dec_ready_i) begin
			hold_valid_q <= 1'b0;
		end
	end

	// hold copy of pc and instruction
	always_ff @(posedge clock) begin
		if (cache_ready) begin
			hold_q <= fresh;
		end
	end

	// fresh result goes straight through, saves a cycle
	assign dec_valid_o = cache_ready || hold_valid_q;
	assign dec_out_o   = cache_ready ? fresh : hold_q;

	// fence.i on a completed transfer wipes the cache
	assign dec_inst = dec_out_o.inst;
	assign flush    = dec_valid_o && dec_ready_i && is_fence_i(dec_inst);

	icache icache_inst (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid_q),
		.fetch_addr_i  (pc_q),
		.flush_i       (flush),
		.cache_ready_o (cache_ready),
		.cache_data_o  (cache_data),
		.mem_resp_i    (mem_resp_i),
		.mem_req_o     (mem_req_o)
	);

	// back end sends either a jump or a retire, not both at once
	a_jump_retire_excl: assert property (@(posedge clock) disable iff (reset)
		!(jump_valid_i && retire_i));

	// held result stays put until decode takes it
	a_hold_stable: assert property (@(posedge clock) disable iff (reset)
		(dec_valid_o && !dec_ready_i) |=> (dec_valid_o && $stable(dec_out_o)));

endmodule

//--- design/icache.sv
`timescale 1ns/10ps

module icache import fetch_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// fetch unit side
	input  logic                  fetch_valid_i,
	input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
	input  logic                  flush_i,
	output logic                  cache_ready_o,
	output logic [WORD_WIDTH-1:0] cache_data_o,

	// memory side
	input  mem_resp_t             mem_resp_i,
	output mem_req_t              mem_req_o
);

	typedef enum logic [1:0] {
		C_IDLE,
		C_LOOKUP,
		C_REFILL,
		C_RESP
	} cache_state_t;

	cache_state_t                          state_q;
	logic [ADDR_WIDTH-1:0]                 req_addr_q;
	logic [WORD_WIDTH-1:0]                 fill_word_q;

	logic [TAG_BITS-1:0]                   rd_tag;
	logic                                  rd_valid;
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] rd_word;

	logic                                  wr_en;
	logic [OFFSET_BITS-1:0]                wr_offset;
	logic [WORD_WIDTH-1:0]                 wr_data;
	logic                                  refill_done;

	logic                                  hit;
	logic                                  miss;
	logic [ADDR_WIDTH-1:0]                 line_addr;

	// compare stored line against the registered request
	assign hit  = (state_q == C_LOOKUP) && rd_valid && (rd_tag == addr_tag(req_addr_q));
	assign miss = (state_q == C_LOOKUP) && !hit;

	// burst always starts at the line base
	assign line_addr = {addr_tag(req_addr_q), addr_index(req_addr_q),
		{(OFFSET_BITS + BYTE_BITS){1'b0}}};

	// one pulse per request from a hit or after a refill
	assign cache_ready_o = hit || (state_q == C_RESP);
	assign cache_data_o  = (state_q == C_RESP) ? fill_word_q : rd_word[addr_offset(req_addr_q)];

	// request fsm
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= C_IDLE;
		end else begin
			case (state_q)
				C_IDLE: begin
					if (fetch_valid_i) begin
						state_q <= C_LOOKUP;
					end
				end
				C_LOOKUP: begin
					state_q <= hit ? C_IDLE : C_REFILL;
				end
				C_REFILL: begin
					if (refill_done) begin
						state_q <= C_RESP;
					end
				end
				C_RESP: begin
					state_q <= C_IDLE;
				end
				default: begin
					state_q <= C_IDLE;
				end
			endcase
		end
	end

	// request address sampled with the array read
	always_ff @(posedge clock) begin
		if (state_q == C_IDLE && fetch_valid_i) begin
			req_addr_q <= fetch_addr_i;
		end
	end

	// grab the wanted word as it flies past
	always_ff @(posedge clock) begin
		if (state_q == C_REFILL && wr_en && wr_offset == addr_offset(req_addr_q)) begin
			fill_word_q <= wr_data;
		end
	end

	// read index follows the live address and matters only in idle
	icache_array array_inst (
		.clock       (clock),
		.reset       (reset),
		.rd_index_i  (addr_index(fetch_addr_i)),
		.rd_tag_o    (rd_tag),
		.rd_valid_o  (rd_valid),
		.rd_word_o   (rd_word),
		.wr_en_i     (wr_en),
		.wr_index_i  (addr_index(req_addr_q)),
		.wr_offset_i (wr_offset),
		.wr_tag_i    (addr_tag(req_addr_q)),
		.wr_data_i   (wr_data),
		.flush_i     (flush_i)
	);

	icache_refill refill_inst (
		.clock       (clock),
		.reset       (reset),
		.start_i     (miss),
		.line_addr_i (line_addr),
		.mem_resp_i  (mem_resp_i),
		.mem_req_o   (mem_req_o),
		.wr_en_o     (wr_en),
		.wr_offset_o (wr_offset),
		.wr_data_o   (wr_data),
		.done_o      (refill_done)
	);

	// one answer per request and the fetch unit lets go right after
	a_ready_pulse: assert property (@(posedge clock) disable iff (reset)
		cache_ready_o |=> (!cache_ready_o && !fetch_valid_i));

endmodule

//--- design/icache_refill.sv
`timescale 1ns/10ps

module icache_refill import fetch_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,

	// kick from the lookup side, line base address
	input  logic                   start_i,
	input  logic [ADDR_WIDTH-1:0]  line_addr_i,

	// memory port
	input  mem_resp_t              mem_resp_i,
	output mem_req_t               mem_req_o,

	// word writes into the array
	output logic                   wr_en_o,
	output logic [OFFSET_BITS-1:0] wr_offset_o,
	output logic [WORD_WIDTH-1:0]  wr_data_o,
	output logic                   done_o
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_REQ,
		R_FILL
	} refill_state_t;

	refill_state_t          state_q;
	logic [OFFSET_BITS-1:0] beat_cnt_q;
	logic [ADDR_WIDTH-1:0]  line_addr_q;
	logic                   busy;

	assign busy = (state_q != R_IDLE);

	// request is a level for the whole burst
	assign mem_req_o.valid = busy;
	assign mem_req_o.addr  = line_addr_q;
	assign mem_req_o.len   = LEN_WIDTH'(LINE_WORDS - 1);

	// every beat is a word write at the running offset
	assign wr_en_o     = busy && mem_resp_i.beat;
	assign wr_offset_o = beat_cnt_q;
	assign wr_data_o   = mem_resp_i.data;
	assign done_o      = wr_en_o && mem_resp_i.last;

	// req waits for the first beat, fill takes the rest
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= R_IDLE;
		end else begin
			case (state_q)
				R_IDLE: begin
					if (start_i) begin
						state_q <= R_REQ;
					end
				end
				R_REQ: begin
					if (done_o) begin
						state_q <= R_IDLE;
					end else if (wr_en_o) begin
						state_q <= R_FILL;
					end
				end
				R_FILL: begin
					// valid falls the cycle after last
					if (done_o) begin
						state_q <= R_IDLE;
					end
				end
				default: begin
					state_q <= R_IDLE;
				end
			endcase
		end
	end

	// beat counter, restarts with each burst
	always_ff @(posedge clock) begin
		if (reset || start_i) begin
			beat_cnt_q <= '0;
		end else if (wr_en_o) begin
			beat_cnt_q <= beat_cnt_q + 1'b1;
		end
	end

	// line base latched on start
	always_ff @(posedge clock) begin
		if (start_i) begin
			line_addr_q <= line_addr_i;
		end
	end

	// burst length must match the line, last exactly on beat LINE_WORDS
	a_last_on_line_end: assert property (@(posedge clock) disable iff (reset)
		wr_en_o |-> (mem_resp_i.last == (beat_cnt_q == OFFSET_BITS'(LINE_WORDS - 1))));

endmodule

//--- design/icache_array.sv
`timescale 1ns/10ps

module icache_array import fetch_pkg::*; (
	input  logic                                  clock,
	input  logic                                  reset,

	// lookup port, data shows up one cycle later
	input  logic [INDEX_BITS-1:0]                 rd_index_i,
	output logic [TAG_BITS-1:0]                   rd_tag_o,
	output logic                                  rd_valid_o,
	output logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] rd_word_o,

	// refill write port, one word per beat
	input  logic                                  wr_en_i,
	input  logic [INDEX_BITS-1:0]                 wr_index_i,
	input  logic [OFFSET_BITS-1:0]                wr_offset_i,
	input  logic [TAG_BITS-1:0]                   wr_tag_i,
	input  logic [WORD_WIDTH-1:0]                 wr_data_i,

	// drop every line at once
	input  logic                                  flush_i
);

	logic [LINE_COUNT-1:0]                 valid_q;
	logic [TAG_BITS-1:0]                   tag_q  [LINE_COUNT];
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] data_q [LINE_COUNT];
	logic                                  line_done;

	// words arrive in address order, so the top offset closes the line
	assign line_done = wr_en_i && (wr_offset_i == OFFSET_BITS'(LINE_WORDS - 1));

	// valid bits, flush wins over a finishing refill
	always_ff @(posedge clock) begin
		if (reset || flush_i) begin
			valid_q <= '0;
		end else if (line_done) begin
			valid_q[wr_index_i] <= 1'b1;
		end
	end

	// tag and data storage
	always_ff @(posedge clock) begin
		if (wr_en_i) begin
			tag_q[wr_index_i]               <= wr_tag_i;
			data_q[wr_index_i][wr_offset_i] <= wr_data_i;
		end
	end

	// registered read of valid bit
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= valid_q[rd_index_i];
		end
	end

	// registered read of tag and whole line
	always_ff @(posedge clock) begin
		rd_tag_o  <= tag_q[rd_index_i];
		rd_word_o <= data_q[rd_index_i];
	end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	localparam int LEN_WIDTH  = 8;

	// first fetch address out of reset
	localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h3000_0000;

	// direct mapped, 16 lines of 4 words
	localparam int LINE_WORDS  = 4;
	localparam int LINE_COUNT  = 16;
	localparam int BYTE_BITS   = 2;
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int INDEX_BITS  = $clog2(LINE_COUNT);
	localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

	// cache toward memory, len is beats minus one
	typedef struct packed {
		logic                  valid;
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
	} mem_req_t;

	// memory toward cache, one word per beat
	typedef struct packed {
		logic                  beat;
		logic [WORD_WIDTH-1:0] data;
		logic                  last;
	} mem_resp_t;

	// fetch result handed to decode
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] pc;
		logic [WORD_WIDTH-1:0] inst;
	} fetch_out_t;

	// word select inside a line
	function automatic logic [OFFSET_BITS-1:0] addr_offset(input logic [ADDR_WIDTH-1:0] addr);
		return addr[BYTE_BITS +: OFFSET_BITS];
	endfunction

	// line select
	function automatic logic [INDEX_BITS-1:0] addr_index(input logic [ADDR_WIDTH-1:0] addr);
		return addr[BYTE_BITS + OFFSET_BITS +: INDEX_BITS];
	endfunction

	// upper bits kept in the tag store
	function automatic logic [TAG_BITS-1:0] addr_tag(input logic [ADDR_WIDTH-1:0] addr);
		return addr[ADDR_WIDTH-1 -: TAG_BITS];
	endfunction

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

	// instruction word width, rv32 base encoding
	localparam int INST_WIDTH = 32;

	// misc-mem major opcode, shared by fence and fence.i
	localparam logic [6:0] OPCODE_MISC_MEM = 7'b000_1111;

	// funct3 that tells fence.i apart from a plain fence
	localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

	// opcode field, bits 6..0
	function automatic logic [6:0] inst_opcode(input logic [INST_WIDTH-1:0] inst);
		return inst[6:0];
	endfunction

	// funct3 field, bits 14..12
	function automatic logic [2:0] inst_funct3(input logic [INST_WIDTH-1:0] inst);
		return inst[14:12];
	endfunction

	// true for the instruction stream sync instruction
	function automatic logic is_fence_i(input logic [INST_WIDTH-1:0] inst);
		return (inst_opcode(inst) == OPCODE_MISC_MEM) && (inst_funct3(inst) == FUNCT3_FENCE_I);
	endfunction

endpackage
